//--- Makefile
# Verilator build and run of the vector execution slice testbench
TOP := riscv_v_exec_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@grep -q "Everything OK" $(LOG) || (echo "TEST FAILED: no pass line in log"; exit 1)
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir $(LOG)

//--- dv/riscv_v_exec_checker.sv
// Watches the DUT ports on the rising clock edge
// Keeps its own copy of SEW and vl, expects res two edges after each operation
module riscv_v_exec_checker (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cfg_valid,
    input  riscv_v_pkg::riscv_v_avl_t        cfg_avl,
    input  riscv_v_pkg::riscv_v_sew_t        cfg_sew,
    input  logic                             cfg_error,
    input  logic                             op_valid,
    input  riscv_v_pkg::riscv_v_op_t         op,
    input  riscv_v_pkg::riscv_v_data_t       srca,
    input  riscv_v_pkg::riscv_v_data_t       srcb,
    input  riscv_v_pkg::riscv_v_data_t       vd_old,
    input  riscv_v_pkg::riscv_v_byte_flags_t mask,
    input  logic                             res_valid,
    input  riscv_v_pkg::riscv_v_data_t       res,
    output int                               value_errors,
    output int                               protocol_errors,
    output int                               pending
);
    import riscv_v_pkg::*;

    riscv_v_sew_t  model_sew;
    int            model_vl;
    logic          exp_cfg_error;
    int            cycle;
    riscv_v_data_t exp_queue [$];
    int            stamp_queue [$];

    // Each element computed at full width, only its own bytes are kept
    function automatic riscv_v_data_t expected_result(
        input riscv_v_data_t       a,
        input riscv_v_data_t       b,
        input riscv_v_data_t       old,
        input riscv_v_byte_flags_t m,
        input riscv_v_op_t         o,
        input riscv_v_sew_t        sew,
        input int                  vl
    );
        riscv_v_data_t r;
        riscv_v_data_t ae;
        riscv_v_data_t be;
        riscv_v_data_t full;
        int            nb;
        int            j;
        logic          wr;
        r  = old;
        nb = 1 << sew;
        for (int e = 0; e < RISCV_V_NUM_BYTES_DATA / nb; e++) begin
            ae = a >> (e * nb * 8);
            be = b >> (e * nb * 8);
            case (o.alu_op)
                ALU_ADD: full = ae + be;
                ALU_SUB: full = ae + ~be + 128'd1;
                ALU_AND: full = ae & be;
                default: full = ae ^ be;
            endcase
            for (int i = 0; i < nb; i++) begin
                j  = e * nb + i;
                wr = (e < vl) && (!o.use_mask || m[e]) && (!o.is_mask || j < 2);
                if (wr) begin
                    r[j*8 +: 8] = full[i*8 +: 8];
                end
            end
        end
        return r;
    endfunction

    always @(posedge clk) begin : compare
        riscv_v_data_t exp_res;
        int            stamp;
        int            vlmax;
        if (!rst_n) begin
            model_sew       = OSIZE_8;
            model_vl        = 0;
            exp_cfg_error   = 1'b0;
            cycle           = 0;
            value_errors    = 0;
            protocol_errors = 0;
            exp_queue.delete();
            stamp_queue.delete();
        end else begin
            cycle++;
            if (cfg_error !== exp_cfg_error) begin
                $display("FAIL cfg_error: expected %h, got %h", exp_cfg_error, cfg_error);
                value_errors++;
            end
            if (res_valid) begin
                if (exp_queue.size() == 0) begin
                    $display("Result strobe at cycle %0d with no operation in flight", cycle);
                    protocol_errors++;
                end else begin
                    exp_res = exp_queue.pop_front();
                    stamp   = stamp_queue.pop_front();
                    if (cycle != stamp + 2) begin
                        $display("Result came %0d edges after its operation, expected 2",
                                 cycle - stamp);
                        protocol_errors++;
                    end
                    if (res !== exp_res) begin
                        $display("FAIL res: expected %h, got %h", exp_res, res);
                        value_errors++;
                    end
                end
            end
            // Operation in the same cycle as a config strobe sees the old setting
            if (op_valid) begin
                exp_queue.push_back(expected_result(srca, srcb, vd_old, mask, op,
                                                    model_sew, model_vl));
                stamp_queue.push_back(cycle);
            end
            exp_cfg_error = cfg_valid && (cfg_sew > OSIZE_128);
            if (cfg_valid && cfg_sew <= OSIZE_128) begin
                vlmax     = RISCV_V_NUM_ELEMENTS_REG >> cfg_sew;
                model_sew = cfg_sew;
                model_vl  = (int'(cfg_avl) > vlmax) ? vlmax : int'(cfg_avl);
            end
        end
        pending = exp_queue.size();
    end

endmodule

//--- dv/riscv_v_exec_tb.sv
// Testbench for the vector execution slice
// Inputs change on rising edges; checking is done in riscv_v_exec_checker
module riscv_v_exec_tb;
    import riscv_v_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_SIZES  = 5;
    // One cycle per config or operation strobe over all phases
    localparam int NUM_SLOTS  = NUM_SIZES * 9 + NUM_SIZES * 9 + NUM_SIZES * 6 + 10 + 8 + 21;
    localparam int MARGIN     = 40;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                cfg_valid;
    riscv_v_avl_t        cfg_avl;
    riscv_v_sew_t        cfg_sew;
    logic                cfg_error;
    logic                op_valid;
    riscv_v_op_t         op;
    riscv_v_data_t       srca;
    riscv_v_data_t       srcb;
    riscv_v_data_t       vd_old;
    riscv_v_byte_flags_t mask;
    logic                res_valid;
    riscv_v_data_t       res;
    int                  value_errors;
    int                  protocol_errors;
    int                  pending;
    integer              seed = 32'hd13f_f107;
    riscv_v_avl_t        vlmax;
    riscv_v_avl_t        avl;

    always #(CLK_PERIOD / 2) clk = ~clk;

    riscv_v_exec dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_avl   (cfg_avl),
        .cfg_sew   (cfg_sew),
        .cfg_error (cfg_error),
        .op_valid  (op_valid),
        .op        (op),
        .srca      (srca),
        .srcb      (srcb),
        .vd_old    (vd_old),
        .mask      (mask),
        .res_valid (res_valid),
        .res       (res)
    );

    riscv_v_exec_checker check0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_valid       (cfg_valid),
        .cfg_avl         (cfg_avl),
        .cfg_sew         (cfg_sew),
        .cfg_error       (cfg_error),
        .op_valid        (op_valid),
        .op              (op),
        .srca            (srca),
        .srcb            (srcb),
        .vd_old          (vd_old),
        .mask            (mask),
        .res_valid       (res_valid),
        .res             (res),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .pending         (pending)
    );

    function automatic riscv_v_data_t rand_data();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic riscv_v_alu_op_t rand_op();
        return riscv_v_alu_op_t'(rand_word());
    endfunction

    task automatic drive_cfg(input riscv_v_sew_t sew, input riscv_v_avl_t req_avl);
        @(posedge clk);
        cfg_valid <= 1'b1;
        cfg_sew   <= sew;
        cfg_avl   <= req_avl;
        op_valid  <= 1'b0;
    endtask

    // Mask and vd_old are random, so an ignored mask still gets exercised
    task automatic drive_op(
        input riscv_v_alu_op_t alu_op,
        input logic            use_m,
        input logic            is_m,
        input riscv_v_data_t   a,
        input riscv_v_data_t   b
    );
        @(posedge clk);
        cfg_valid       <= 1'b0;
        op_valid        <= 1'b1;
        op.alu_op       <= alu_op;
        op.use_mask     <= use_m;
        op.is_mask      <= is_m;
        srca            <= a;
        srcb            <= b;
        vd_old          <= rand_data();
        mask            <= riscv_v_byte_flags_t'(rand_word());
    endtask

    task automatic idle();
        @(posedge clk);
        cfg_valid <= 1'b0;
        op_valid  <= 1'b0;
    endtask

    initial begin : watchdog
        #((NUM_SLOTS + MARGIN) * CLK_PERIOD);
        $display("Watchdog expired with %0d results outstanding", pending);
        $display("Something failed");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        cfg_valid = 1'b0;
        cfg_avl   = '0;
        cfg_sew   = '0;
        op_valid  = 1'b0;
        op        = '0;
        srca      = '0;
        srcb      = '0;
        vd_old    = '0;
        mask      = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Element sizes at full length with long carry and borrow chains first
        for (int s = 0; s < NUM_SIZES; s++) begin
            drive_cfg(riscv_v_sew_t'(s), 8'd16);
            drive_op(ALU_ADD, 1'b0, 1'b0, {16{8'hff}}, {16{8'h01}});
            drive_op(ALU_SUB, 1'b0, 1'b0, '0, {16{8'h01}});
            for (int i = 0; i < 6; i++) begin
                drive_op(i[0] ? ALU_SUB : ALU_ADD, 1'b0, 1'b0, rand_data(), rand_data());
            end
        end

        // Zero length, one below VLMAX, and a clamped request
        for (int s = 0; s < NUM_SIZES; s++) begin
            vlmax = riscv_v_avl_t'(RISCV_V_NUM_ELEMENTS_REG >> s);
            for (int t = 0; t < 3; t++) begin
                case (t)
                    0: avl = 8'd0;
                    1: avl = vlmax - 8'd1;
                    default: avl = 8'd200;
                endcase
                drive_cfg(riscv_v_sew_t'(s), avl);
                repeat (2) drive_op(rand_op(), 1'b0, 1'b0, rand_data(), rand_data());
            end
        end

        // Element masking, then a mask destination
        for (int s = 0; s < NUM_SIZES; s++) begin
            drive_cfg(riscv_v_sew_t'(s), 8'd16);
            repeat (3) drive_op(rand_op(), 1'b1, 1'b0, rand_data(), rand_data());
            repeat (2) drive_op(rand_op(), 1'b0, 1'b1, rand_data(), rand_data());
        end

        // Logic operations under partial length and mask
        for (int s = 1; s < 4; s += 2) begin
            drive_cfg(riscv_v_sew_t'(s), 8'd3);
            drive_op(ALU_AND, 1'b0, 1'b0, rand_data(), rand_data());
            drive_op(ALU_XOR, 1'b0, 1'b0, rand_data(), rand_data());
            drive_op(ALU_AND, 1'b1, 1'b0, rand_data(), rand_data());
            drive_op(ALU_XOR, 1'b1, 1'b0, rand_data(), rand_data());
        end

        // Reserved SEW codes must leave the 32-bit setting in place
        drive_cfg(OSIZE_32, 8'd16);
        drive_cfg(3'd5, 8'd3);
        drive_op(ALU_ADD, 1'b0, 1'b0, rand_data(), rand_data());
        drive_op(ALU_SUB, 1'b0, 1'b0, rand_data(), rand_data());
        drive_cfg(3'd7, 8'd1);
        drive_op(ALU_ADD, 1'b0, 1'b0, rand_data(), rand_data());
        drive_op(ALU_ADD, 1'b0, 1'b0, rand_data(), rand_data());
        cfg_valid <= 1'b1;
        cfg_sew   <= OSIZE_8;
        cfg_avl   <= 8'd5;
        drive_op(ALU_SUB, 1'b0, 1'b0, rand_data(), rand_data());

        // Random back-to-back traffic
        drive_cfg(OSIZE_16, 8'd6);
        repeat (20) begin
            drive_op(rand_op(), 1'(rand_word()), 1'(rand_word()),
                     rand_data(), rand_data());
        end
        // Four idle cycles drain the two-edge pipeline
        repeat (4) idle();
        @(negedge clk);

        if (pending != 0) begin
            $display("%0d results never arrived", pending);
        end
        $display("Errors: value %0d, protocol %0d, missing %0d",
                 value_errors, protocol_errors, pending);
        if (value_errors == 0 && protocol_errors == 0 && pending == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- source/riscv_v_alu.sv
// Two-stage segmented vector ALU for add, sub, and, xor on 8 to 128-bit elements
// Result byte comes from vd_old wherever valid is clear (mask-undisturbed)
// res_valid follows op_valid by exactly two clocks without stall
module riscv_v_alu (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           op_valid,
    input  riscv_v_pkg::riscv_v_op_t       op,
    input  riscv_v_pkg::riscv_v_alu_data_t srca_alu,
    input  riscv_v_pkg::riscv_v_alu_data_t srcb_alu,
    input  riscv_v_pkg::riscv_v_data_t     vd_old,
    output logic                           res_valid,
    output riscv_v_pkg::riscv_v_data_t     res
);
    import riscv_v_pkg::*;

    logic              s1_valid;
    riscv_v_alu_op_t   s1_op;
    riscv_v_alu_data_t s1_a;
    riscv_v_data_t     s1_b_data;
    riscv_v_data_t     s1_vd_old;

    riscv_v_data_t     sum;
    riscv_v_data_t     alu_out;
    riscv_v_data_t     merged;
    logic              is_sub;

    // Stage 1 operand capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= op_valid;
        end
    end

    // Merge and valid of operand b repeat those of operand a
    always_ff @(posedge clk) begin
        if (op_valid) begin
            s1_op     <= op.alu_op;
            s1_a      <= srca_alu;
            s1_b_data <= srcb_alu.data;
            s1_vd_old <= vd_old;
        end
    end

    assign is_sub = (s1_op == ALU_SUB);

    // Byte adders with the chain broken where merge is clear
    // Subtract injects a carry of 1 at each element's lowest byte
    always_comb begin : p_adder
        logic       carry;
        logic [8:0] byte_sum;
        logic [7:0] b_byte;
        carry = is_sub;
        for (int j = 0; j < RISCV_V_NUM_BYTES_DATA; j++) begin
            b_byte = is_sub ? ~s1_b_data[j*8 +: 8] : s1_b_data[j*8 +: 8];
            byte_sum = {1'b0, s1_a.data[j*8 +: 8]} + {1'b0, b_byte} + {8'd0, carry};
            sum[j*8 +: 8] = byte_sum[7:0];
            carry = s1_a.merge[j] ? byte_sum[8] : is_sub;
        end
    end

    always_comb begin
        case (s1_op)
            ALU_AND: alu_out = s1_a.data & s1_b_data;
            ALU_XOR: alu_out = s1_a.data ^ s1_b_data;
            default: alu_out = sum;
        endcase
    end

    // Keep old destination bytes outside the valid set
    always_comb begin
        for (int j = 0; j < RISCV_V_NUM_BYTES_DATA; j++) begin
            merged[j*8 +: 8] = s1_a.valid[j] ? alu_out[j*8 +: 8] : s1_vd_old[j*8 +: 8];
        end
    end

    // Stage 2 result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            res <= merged;
        end
    end

endmodule

//--- source/riscv_v_csr.sv
// Vector configuration register, a reduced vsetvl
// New setting is visible one clock after cfg_valid
// Reserved SEW codes keep the old setting and pulse cfg_error
module riscv_v_csr (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cfg_valid,
    input  riscv_v_pkg::riscv_v_avl_t  cfg_avl,
    input  riscv_v_pkg::riscv_v_sew_t  cfg_sew,
    output riscv_v_pkg::riscv_v_cfg_t  cfg,
    output logic                       cfg_error
);
    import riscv_v_pkg::*;

    riscv_v_vl_t vlmax;
    riscv_v_vl_t vl_clamped;
    logic        sew_ok;

    // VLMAX halves with every step up in element width
    assign vlmax  = riscv_v_vl_t'(RISCV_V_NUM_ELEMENTS_REG) >> cfg_sew;
    assign sew_ok = (cfg_sew <= OSIZE_128);

    // Requested length above VLMAX is cut down to VLMAX
    always_comb begin
        if (cfg_avl > riscv_v_avl_t'(vlmax)) begin
            vl_clamped = vlmax;
        end else begin
            vl_clamped = riscv_v_vl_t'(cfg_avl);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (cfg_valid && sew_ok) begin
            cfg.vsew <= cfg_sew;
            cfg.vl   <= vl_clamped;
        end
    end

    // Single-cycle error flag for a rejected configuration
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_error <= 1'b0;
        end else begin
            cfg_error <= cfg_valid && !sew_ok;
        end
    end

endmodule

//--- source/riscv_v_decode_element.sv
// Combinational element decoder
// Builds per-byte carry merge and write-valid vectors from SEW, vl and mask
// mask bit i applies to element i, whatever the element width
// is_mask only restricts writes to the two bytes of a mask register
module riscv_v_decode_element (
    input  riscv_v_pkg::riscv_v_data_t       srca,
    input  riscv_v_pkg::riscv_v_data_t       srcb,
    input  riscv_v_pkg::riscv_v_cfg_t        cfg,
    input  logic                             is_mask,
    input  logic                             use_mask,
    input  riscv_v_pkg::riscv_v_byte_flags_t mask,
    output riscv_v_pkg::riscv_v_alu_data_t   srca_alu,
    output riscv_v_pkg::riscv_v_alu_data_t   srcb_alu
);
    import riscv_v_pkg::*;

    osize_vector_t       osize_vector;
    riscv_v_byte_flags_t merge_osize [RISCV_V_NUM_VALID_OSIZES];
    riscv_v_byte_flags_t valid_osize [RISCV_V_NUM_VALID_OSIZES];
    riscv_v_byte_flags_t valid_is_mask;
    riscv_v_byte_flags_t merge;
    riscv_v_byte_flags_t valid;

    // One element flag per slot: inside vl and not masked off
    logic [RISCV_V_NUM_ELEMENTS_REG-1:0] elem_active;

    // One-hot of the active element size
    assign osize_vector[0] = (cfg.vsew == OSIZE_8);
    assign osize_vector[1] = (cfg.vsew == OSIZE_16);
    assign osize_vector[2] = (cfg.vsew == OSIZE_32);
    assign osize_vector[3] = (cfg.vsew == OSIZE_64);
    assign osize_vector[4] = (cfg.vsew == OSIZE_128);

    generate
        for (genvar e = 0; e < RISCV_V_NUM_ELEMENTS_REG; e++) begin : gen_elem
            assign elem_active[e] = (cfg.vl > riscv_v_vl_t'(e)) && (!use_mask || mask[e]);
        end
    endgenerate

    // Mask destination: only the low bytes may be written
    assign valid_is_mask = {
        {(RISCV_V_NUM_BYTES_DATA - RISCV_V_NUM_BYTES_ALLOCATE_MASK){~is_mask}},
        {RISCV_V_NUM_BYTES_ALLOCATE_MASK{1'b1}}
    };

    // Per-size patterns, zero unless that size is selected
    generate
        for (genvar k = 0; k < RISCV_V_NUM_VALID_OSIZES; k++) begin : gen_osize
            localparam int BYTES_PER_ELEM = 1 << k;

            always_comb begin
                merge_osize[k] = '0;
                valid_osize[k] = '0;
                for (int j = 0; j < RISCV_V_NUM_BYTES_DATA; j++) begin
                    // Carry crosses every byte boundary except an element's top byte
                    merge_osize[k][j] = osize_vector[k] && (((j + 1) % BYTES_PER_ELEM) != 0);
                    valid_osize[k][j] = osize_vector[k] && elem_active[j >> k];
                end
            end
        end
    endgenerate

    always_comb begin
        merge = '0;
        valid = '0;
        for (int k = 0; k < RISCV_V_NUM_VALID_OSIZES; k++) begin
            merge |= merge_osize[k];
            valid |= valid_osize[k];
        end
        valid &= valid_is_mask;
    end

    assign srca_alu.data  = srca;
    assign srca_alu.merge = merge;
    assign srca_alu.valid = valid;

    // Both operands carry the same element layout
    assign srcb_alu.data  = srcb;
    assign srcb_alu.merge = merge;
    assign srcb_alu.valid = valid;

endmodule

//--- source/riscv_v_exec.sv
// Vector execution slice top: CSR, element decoder, segmented ALU
// Operation on the same cycle as cfg_valid still sees the old configuration
// Nothing is written until the first accepted configuration
module riscv_v_exec (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cfg_valid,
    input  riscv_v_pkg::riscv_v_avl_t        cfg_avl,
    input  riscv_v_pkg::riscv_v_sew_t        cfg_sew,
    output logic                             cfg_error,
    input  logic                             op_valid,
    input  riscv_v_pkg::riscv_v_op_t         op,
    input  riscv_v_pkg::riscv_v_data_t       srca,
    input  riscv_v_pkg::riscv_v_data_t       srcb,
    input  riscv_v_pkg::riscv_v_data_t       vd_old,
    input  riscv_v_pkg::riscv_v_byte_flags_t mask,
    output logic                             res_valid,
    output riscv_v_pkg::riscv_v_data_t       res
);
    import riscv_v_pkg::*;

    riscv_v_cfg_t      cfg;
    riscv_v_alu_data_t srca_alu;
    riscv_v_alu_data_t srcb_alu;

    riscv_v_csr u_csr (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_avl   (cfg_avl),
        .cfg_sew   (cfg_sew),
        .cfg       (cfg),
        .cfg_error (cfg_error)
    );

    // Combinational, sampled by the ALU together with op_valid
    riscv_v_decode_element u_decode (
        .srca     (srca),
        .srcb     (srcb),
        .cfg      (cfg),
        .is_mask  (op.is_mask),
        .use_mask (op.use_mask),
        .mask     (mask),
        .srca_alu (srca_alu),
        .srcb_alu (srcb_alu)
    );

    riscv_v_alu u_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_valid  (op_valid),
        .op        (op),
        .srca_alu  (srca_alu),
        .srcb_alu  (srcb_alu),
        .vd_old    (vd_old),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

//--- source/riscv_v_pkg.sv
// Shared sizes, types and opcodes for the 128-bit vector execution slice
// No LMUL grouping, so one register holds at most 16 elements
// SEW codes 5 to 7 are reserved and rejected by the CSR
package riscv_v_pkg;

    // Register geometry
    localparam int RISCV_V_NUM_BYTES_DATA          = 16;
    localparam int RISCV_V_DATA_WIDTH              = 128;
    localparam int RISCV_V_NUM_VALID_OSIZES        = 5;
    localparam int RISCV_V_NUM_ELEMENTS_REG        = 16;
    localparam int RISCV_V_NUM_BYTES_ALLOCATE_MASK = 2;

    typedef logic [RISCV_V_DATA_WIDTH-1:0]      riscv_v_data_t;
    typedef logic [RISCV_V_NUM_BYTES_DATA-1:0]  riscv_v_byte_flags_t;
    typedef logic [2:0]                         riscv_v_sew_t;
    // Needs one extra bit to hold the full count of 16
    typedef logic [$clog2(RISCV_V_NUM_ELEMENTS_REG+1)-1:0] riscv_v_vl_t;
    typedef logic [7:0]                         riscv_v_avl_t;
    typedef logic [1:0]                         riscv_v_alu_op_t;
    typedef logic [RISCV_V_NUM_VALID_OSIZES-1:0] osize_vector_t;

    // Element width codes
    localparam riscv_v_sew_t OSIZE_8   = 3'd0;
    localparam riscv_v_sew_t OSIZE_16  = 3'd1;
    localparam riscv_v_sew_t OSIZE_32  = 3'd2;
    localparam riscv_v_sew_t OSIZE_64  = 3'd3;
    localparam riscv_v_sew_t OSIZE_128 = 3'd4;

    // ALU opcodes
    localparam riscv_v_alu_op_t ALU_ADD = 2'd0;
    localparam riscv_v_alu_op_t ALU_SUB = 2'd1;
    localparam riscv_v_alu_op_t ALU_AND = 2'd2;
    localparam riscv_v_alu_op_t ALU_XOR = 2'd3;

    typedef struct packed {
        riscv_v_sew_t vsew;
        riscv_v_vl_t  vl;
    } riscv_v_cfg_t;

    typedef struct packed {
        riscv_v_alu_op_t alu_op;
        logic            use_mask;
        logic            is_mask;
    } riscv_v_op_t;

    // Operand plus per-byte carry merge and write enables
    typedef struct packed {
        riscv_v_data_t       data;
        riscv_v_byte_flags_t merge;
        riscv_v_byte_flags_t valid;
    } riscv_v_alu_data_t;

endpackage

//--- src.f
source/riscv_v_pkg.sv
source/riscv_v_csr.sv
source/riscv_v_decode_element.sv
source/riscv_v_alu.sv
source/riscv_v_exec.sv
dv/riscv_v_exec_checker.sv
dv/riscv_v_exec_tb.sv
